// ==== Bender.yml ====
package:
  name: weight_loader

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/conv_layer_pkg.sv
      - rtl/loader_pkg.sv
      - rtl/group_fetch_ctrl.sv
      - rtl/column_skew_sequencer.sv
      - rtl/weight_column_buffer.sv
      - rtl/weight_loader.sv
  - target: simulation
    files:
      - tb/tb_weight_loader.sv

// ==== rtl/column_skew_sequencer.sv ====
`timescale 1ns/100ps
`include "weight_loader_consts.svh"

module column_skew_sequencer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 stream_start,          // Held for one unstalled cycle
    output logic [`WL_SA_N-1:0]  col_active,            // Column shows a buffer entry
    output loader_pkg::buf_pos_t col_pos [`WL_SA_N],    // Entry each column reads
    output logic                 stream_done            // Final zero cycle of last column
);
    import loader_pkg::*;

    localparam int DLY_W   = $clog2(`WL_SA_N);
    localparam int PHASE_W = $clog2(`WL_WEIGHT_CYCLES);

    logic [`WL_SA_N-1:0] col_parked;       // Idle or done, ready for a new stream

    for (genvar c = 0; c < `WL_SA_N; c++) begin : g_col
        col_state_t         state;
        logic [DLY_W-1:0]   dly_cnt;            // Skew cycles still to wait
        logic [PHASE_W-1:0] phase_cnt;          // Cycle within burst or gap
        buf_pos_t           pos_cnt;            // Next kernel position to send

        always_ff @(posedge clk) begin
            if (reset) begin
                state     <= COL_IDLE;
                dly_cnt   <= '0;
                phase_cnt <= '0;
                pos_cnt   <= '0;
            end else if (!stall) begin
                case (state)
                    COL_IDLE, COL_DONE: begin
                        if (stream_start) begin
                            phase_cnt <= '0;
                            pos_cnt   <= '0;
                            dly_cnt   <= DLY_W'((c > 0) ? c - 1 : 0);
                            state     <= (c == 0) ? COL_WEIGHT : COL_DELAY;  // Col 0 no skew
                        end
                    end

                    COL_DELAY: begin
                        dly_cnt <= dly_cnt - 1'b1;
                        if (dly_cnt == '0) begin
                            state <= COL_WEIGHT;
                        end
                    end

                    COL_WEIGHT: begin
                        pos_cnt <= pos_cnt + 1'b1;      // Wraps to 0 after entry 15
                        if (phase_cnt == PHASE_W'(`WL_WEIGHT_CYCLES - 1)) begin
                            phase_cnt <= '0;
                            state     <= COL_ZERO;
                        end else begin
                            phase_cnt <= phase_cnt + 1'b1;
                        end
                    end

                    COL_ZERO: begin
                        if (phase_cnt == PHASE_W'(`WL_ZERO_CYCLES - 1)) begin
                            phase_cnt <= '0;
                            // Wrapped position means all 16 entries went out
                            state <= (pos_cnt == '0) ? COL_DONE : COL_WEIGHT;
                        end else begin
                            phase_cnt <= phase_cnt + 1'b1;
                        end
                    end

                    default: state <= COL_IDLE;
                endcase
            end
        end

        assign col_active[c] = (state == COL_WEIGHT);
        assign col_pos[c]    = pos_cnt;
        assign col_parked[c] = (state == COL_IDLE) || (state == COL_DONE);

        // Last column finishes last, S30 of the stream
        if (c == `WL_SA_N - 1) begin : g_done
            assign stream_done = (state == COL_ZERO) && (pos_cnt == '0) &&
                                 (phase_cnt == PHASE_W'(`WL_ZERO_CYCLES - 1));
        end
    end

    // New group only once the previous stream has fully drained
    a_start_when_parked: assert property (@(posedge clk) disable iff (reset)
        stream_start |-> &col_parked);

endmodule

// ==== rtl/conv_layer_pkg.sv ====
`include "weight_loader_consts.svh"

package conv_layer_pkg;

    typedef logic [$clog2(`WL_NUM_LAYERS)-1:0] layer_idx_t;     // 3 bits
    typedef logic [7:0] out_ch_idx_t;                             // Output filter
    // Group count needs one spare code for the full 64 groups
    typedef logic [$clog2(`WL_MAX_NUM_CH/`WL_VECTOR_WIDTH+1)-1:0] ch_group_t;
    typedef logic [$clog2(`WL_ROM_DEPTH)-1:0] rom_addr_t;         // 15 bits
    typedef logic [8*`WL_VECTOR_WIDTH-1:0] rom_word_t;            // Channel 0 in top byte

    // Per-layer channel counts
    localparam int LAYER_IN_CH [`WL_NUM_LAYERS] = '{1, 8, 16, 32, 256, 64};
    localparam int LAYER_OUT_CH [`WL_NUM_LAYERS] = '{8, 16, 32, 64, 64, 10};

    // Channel groups of four, rounded up
    function automatic ch_group_t layer_groups(layer_idx_t idx);
        int in_ch;
        // Out-of-table index behaves as a single group
        in_ch = (int'(idx) < `WL_NUM_LAYERS) ? LAYER_IN_CH[idx] : `WL_VECTOR_WIDTH;
        return ch_group_t'((in_ch + `WL_VECTOR_WIDTH - 1) / `WL_VECTOR_WIDTH);
    endfunction

    // First ROM word of a layer
    // Every earlier layer takes filters x rows x groups words
    function automatic rom_addr_t layer_base(layer_idx_t idx);
        rom_addr_t base;
        base = '0;
        for (int i = 0; i < `WL_NUM_LAYERS; i++) begin
            if (i < int'(idx)) begin
                base += rom_addr_t'(LAYER_OUT_CH[i] * `WL_KERNEL_SIZE *
                                    int'(layer_groups(layer_idx_t'(i))));
            end
        end
        return base;                                    // 0, 32, 160, 672, 2720, 19104
    endfunction

endpackage

// ==== rtl/group_fetch_ctrl.sv ====
`timescale 1ns/100ps
`include "weight_loader_consts.svh"

module group_fetch_ctrl (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,          // Pulse, sampled in idle or done
    input  logic                        stall,          // Freezes everything
    input  conv_layer_pkg::layer_idx_t  layer_idx,      // Held while running
    input  conv_layer_pkg::out_ch_idx_t out_ch_idx,     // Held while running
    input  logic                        stream_done,    // Column 3 on its last zero cycle
    output logic                        weight_rom_read_enable,
    output conv_layer_pkg::rom_addr_t   weight_rom_addr,
    output logic                        row_write,      // Buffer row strobe
    output logic [1:0]                  row_sel,        // Kernel row being loaded
    output logic                        stream_start,   // Last load cycle
    output logic                        idle,
    output logic                        weight_load_complete
);
    import conv_layer_pkg::*;
    import loader_pkg::*;

    fetch_state_t state;
    logic [1:0]   row_cnt;              // Kernel row of the current ROM read
    ch_group_t    grp_cnt;              // Channel group being processed
    ch_group_t    num_groups;
    logic         last_row;
    logic         last_group;
    rom_addr_t    filter_offset;        // Start of this filter inside the layer
    rom_addr_t    group_offset;

    assign num_groups = layer_groups(layer_idx);
    assign last_row   = (row_cnt == 2'(`WL_KERNEL_SIZE - 1));
    assign last_group = (grp_cnt == num_groups - 1'b1);

    // Address = base + filter x 4 x groups + group x 4 + row
    assign filter_offset = rom_addr_t'(out_ch_idx) * rom_addr_t'(`WL_KERNEL_SIZE) *
                           rom_addr_t'(num_groups);
    assign group_offset  = rom_addr_t'(grp_cnt) * rom_addr_t'(`WL_KERNEL_SIZE);

    assign weight_rom_addr = layer_base(layer_idx) + filter_offset + group_offset +
                             rom_addr_t'(row_cnt);

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= FETCH_IDLE;
            row_cnt <= '0;
            grp_cnt <= '0;
        end else if (!stall) begin
            case (state)
                FETCH_IDLE, FETCH_DONE: begin
                    if (start) begin            // L0 of group 0 next cycle
                        state   <= FETCH_LOAD;
                        row_cnt <= '0;
                        grp_cnt <= '0;
                    end
                end

                FETCH_LOAD: begin
                    row_cnt <= row_cnt + 2'd1;  // Wraps to 0 after row 3
                    if (last_row) begin
                        state <= FETCH_STREAM;
                    end
                end

                FETCH_STREAM: begin
                    // Buffer is only refilled once every column has finished
                    if (stream_done) begin
                        if (last_group) begin
                            state <= FETCH_DONE;
                        end else begin
                            grp_cnt <= grp_cnt + 1'b1;
                            state   <= FETCH_LOAD;
                        end
                    end
                end

                default: state <= FETCH_IDLE;
            endcase
        end
    end

    assign weight_rom_read_enable = (state == FETCH_LOAD) && !stall;
    assign row_write    = (state == FETCH_LOAD);        // Buffer drops it under stall
    assign row_sel      = row_cnt;
    assign stream_start = (state == FETCH_LOAD) && last_row;     // S0 follows this cycle

    assign idle                 = (state == FETCH_IDLE);
    assign weight_load_complete = (state == FETCH_DONE);  // Held until the next start

    // ROM reads stay inside the group range of the selected layer
    a_read_in_layer: assert property (@(posedge clk) disable iff (reset)
        weight_rom_read_enable |-> (grp_cnt < num_groups));

    // Sequencer finishes only a stream this FSM started
    a_done_in_stream: assert property (@(posedge clk) disable iff (reset)
        stream_done |-> (state == FETCH_STREAM));

endmodule

// ==== rtl/loader_pkg.sv ====
`include "weight_loader_consts.svh"

package loader_pkg;

    typedef logic signed [7:0] weight_t;                        // One int8 weight

    // Index is the input channel within the group
    typedef weight_t [`WL_VECTOR_WIDTH-1:0] weight_vec_t;

    // Row-major kernel position, row in the upper bits
    typedef logic [$clog2(`WL_KERNEL_SIZE*`WL_KERNEL_SIZE)-1:0] buf_pos_t;

    // Group fetch FSM
    typedef enum logic [1:0] {
        FETCH_IDLE,                     // Nothing started since reset
        FETCH_LOAD,                     // Reading four ROM rows
        FETCH_STREAM,                   // Columns playing out the buffer
        FETCH_DONE                      // All groups of the layer sent
    } fetch_state_t;

    // Per-column playout FSM
    typedef enum logic [2:0] {
        COL_IDLE,
        COL_DELAY,                      // Skew wait, column index cycles
        COL_WEIGHT,                     // Buffer entry on the B output
        COL_ZERO,                       // Gap after a burst
        COL_DONE
    } col_state_t;

endpackage

// ==== rtl/weight_column_buffer.sv ====
`timescale 1ns/100ps
`include "weight_loader_consts.svh"

module weight_column_buffer (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        stall,
    input  logic                        row_write,
    input  logic [1:0]                  row_sel,
    input  conv_layer_pkg::rom_word_t   weight_rom_data0,   // Kernel column 3
    input  conv_layer_pkg::rom_word_t   weight_rom_data1,
    input  conv_layer_pkg::rom_word_t   weight_rom_data2,
    input  conv_layer_pkg::rom_word_t   weight_rom_data3,   // Kernel column 0
    input  logic [`WL_SA_N-1:0]         col_active,
    input  loader_pkg::buf_pos_t        col_pos [`WL_SA_N],
    output loader_pkg::weight_vec_t     b0,
    output loader_pkg::weight_vec_t     b1,
    output loader_pkg::weight_vec_t     b2,
    output loader_pkg::weight_vec_t     b3
);
    import conv_layer_pkg::*;
    import loader_pkg::*;

    localparam int NUM_POS = `WL_KERNEL_SIZE * `WL_KERNEL_SIZE;

    weight_vec_t                buf_mem [NUM_POS];          // Row-major kernel slice
    logic [`WL_KERNEL_SIZE-1:0] row_loaded;                 // Rows written since reset
    rom_word_t                  row_words [`WL_KERNEL_SIZE];  // Indexed by kernel column
    weight_vec_t                b_col [`WL_SA_N];

    // Top byte of a ROM word is channel 0
    function automatic weight_vec_t unpack_word(rom_word_t word);
        weight_vec_t vec;
        for (int ch = 0; ch < `WL_VECTOR_WIDTH; ch++) begin
            vec[ch] = word[8*(`WL_VECTOR_WIDTH-1-ch) +: 8];
        end
        return vec;
    endfunction

    assign row_words[0] = weight_rom_data3;
    assign row_words[1] = weight_rom_data2;
    assign row_words[2] = weight_rom_data1;
    assign row_words[3] = weight_rom_data0;

    always_ff @(posedge clk) begin
        if (row_write && !stall) begin
            for (int k = 0; k < `WL_KERNEL_SIZE; k++) begin
                buf_mem[{row_sel, 2'(k)}] <= unpack_word(row_words[k]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            row_loaded <= '0;
        end else if (row_write && !stall) begin
            row_loaded[row_sel] <= 1'b1;
        end
    end

    // Zeros in skew, gap and idle cycles; never an unwritten entry
    always_comb begin
        for (int c = 0; c < `WL_SA_N; c++) begin
            if (col_active[c] && row_loaded[col_pos[c][3:2]]) begin
                b_col[c] = buf_mem[col_pos[c]];
            end else begin
                b_col[c] = '0;
            end
        end
    end

    assign b0 = b_col[0];
    assign b1 = b_col[1];
    assign b2 = b_col[2];
    assign b3 = b_col[3];

    // Sequencer never reaches a row the fetch side has not written
    for (genvar c = 0; c < `WL_SA_N; c++) begin : g_chk
        a_read_loaded_row: assert property (@(posedge clk) disable iff (reset)
            col_active[c] |-> row_loaded[col_pos[c][3:2]]);
    end

endmodule

// ==== rtl/weight_loader.sv ====
`timescale 1ns/100ps
`include "weight_loader_consts.svh"

module weight_loader (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        start,
    input  logic                        stall,
    input  conv_layer_pkg::layer_idx_t  layer_idx,
    input  conv_layer_pkg::out_ch_idx_t out_ch_idx,
    output logic                        weight_rom_read_enable,
    output conv_layer_pkg::rom_addr_t   weight_rom_addr,
    input  conv_layer_pkg::rom_word_t   weight_rom_data0,
    input  conv_layer_pkg::rom_word_t   weight_rom_data1,
    input  conv_layer_pkg::rom_word_t   weight_rom_data2,
    input  conv_layer_pkg::rom_word_t   weight_rom_data3,
    output loader_pkg::weight_vec_t     b0,                 // Array B column 0
    output loader_pkg::weight_vec_t     b1,
    output loader_pkg::weight_vec_t     b2,
    output loader_pkg::weight_vec_t     b3,
    output logic                        idle,
    output logic                        weight_load_complete
);
    import loader_pkg::*;

    logic                row_write;
    logic [1:0]          row_sel;
    logic                stream_start;      // Fetch to sequencer, in L3
    logic                stream_done;       // Sequencer back to fetch, in S30
    logic [`WL_SA_N-1:0] col_active;
    buf_pos_t            col_pos [`WL_SA_N];

    group_fetch_ctrl u_group_fetch_ctrl (
        .clk                    (clk),
        .reset                  (reset),
        .start                  (start),
        .stall                  (stall),
        .layer_idx              (layer_idx),
        .out_ch_idx             (out_ch_idx),
        .stream_done            (stream_done),
        .weight_rom_read_enable (weight_rom_read_enable),
        .weight_rom_addr        (weight_rom_addr),
        .row_write              (row_write),
        .row_sel                (row_sel),
        .stream_start           (stream_start),
        .idle                   (idle),
        .weight_load_complete   (weight_load_complete)
    );

    column_skew_sequencer u_column_skew_sequencer (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .stream_start (stream_start),
        .col_active   (col_active),
        .col_pos      (col_pos),
        .stream_done  (stream_done)
    );

    // ROM words go straight into the buffer row
    weight_column_buffer u_weight_column_buffer (
        .clk              (clk),
        .reset            (reset),
        .stall            (stall),
        .row_write        (row_write),
        .row_sel          (row_sel),
        .weight_rom_data0 (weight_rom_data0),
        .weight_rom_data1 (weight_rom_data1),
        .weight_rom_data2 (weight_rom_data2),
        .weight_rom_data3 (weight_rom_data3),
        .col_active       (col_active),
        .col_pos          (col_pos),
        .b0               (b0),
        .b1               (b1),
        .b2               (b2),
        .b3               (b3)
    );

endmodule

// ==== rtl/weight_loader_consts.svh ====
`ifndef WEIGHT_LOADER_CONSTS_SVH
`define WEIGHT_LOADER_CONSTS_SVH

// Systolic array geometry
`define WL_SA_N 4                 // B columns driven by the loader
`define WL_VECTOR_WIDTH 4         // Input channels packed per buffer entry
`define WL_KERNEL_SIZE 4          // Kernel side, rows and columns

// Network table bounds
`define WL_NUM_LAYERS 6
`define WL_MAX_NUM_CH 256         // Widest input channel count in the table

// Weight ROM
// One word per kernel column, four words per row read
`define WL_ROM_DEPTH 32768        // 15 address bits

// Column burst shape
// Each burst is followed by a zero gap so the array can drain the partial sums
`define WL_WEIGHT_CYCLES 4        // Weights per burst
`define WL_ZERO_CYCLES 3          // Zero gap after each burst

`endif

// ==== tb/tb_weight_loader.sv ====
`timescale 1ns/100ps

module tb_weight_loader;
    import conv_layer_pkg::*;
    import loader_pkg::*;

    localparam int LOAD_CYCLES  = 4;
    localparam int GROUP_CYCLES = 35;                   // 4 load + 31 stream
    // Groups run: 1 + 2 + 16 + 4, margin covers stalls and gaps
    localparam int TIMEOUT_CYCLES = 2 * (GROUP_CYCLES * 23 + 100);

    localparam int EXP_BASE [6]   = '{0, 32, 160, 672, 2720, 19104};
    localparam int EXP_GROUPS [6] = '{1, 2, 4, 8, 64, 16};

    logic        clk;
    logic        reset;
    logic        start;
    logic        stall;
    layer_idx_t  layer_idx;
    out_ch_idx_t out_ch_idx;
    logic        weight_rom_read_enable;
    rom_addr_t   weight_rom_addr;
    rom_word_t   rom_data [4];
    weight_vec_t b_seen [4];
    logic        idle;
    logic        weight_load_complete;
    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          cycle_cnt;
    int          run_stalls;

    weight_loader u_weight_loader (
        .clk(clk), .reset(reset), .start(start), .stall(stall),
        .layer_idx(layer_idx), .out_ch_idx(out_ch_idx),
        .weight_rom_read_enable(weight_rom_read_enable), .weight_rom_addr(weight_rom_addr),
        .weight_rom_data0(rom_data[0]), .weight_rom_data1(rom_data[1]),
        .weight_rom_data2(rom_data[2]), .weight_rom_data3(rom_data[3]),
        .b0(b_seen[0]), .b1(b_seen[1]), .b2(b_seen[2]), .b3(b_seen[3]),
        .idle(idle), .weight_load_complete(weight_load_complete)
    );

    always #4 clk = ~clk;                               // 8 ns period

    // Fixed mix of full address and word index
    function automatic rom_word_t rom_word(rom_addr_t addr, int idx);
        logic [31:0] x;
        x = (32'(addr) * 32'd4 + 32'(idx)) * 32'h9e3779b1;
        x = x ^ (x >> 13);
        x = x * 32'h85ebca6b;
        return x ^ (x >> 16);
    endfunction

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            rom_data[j] = rom_word(weight_rom_addr, j);  // Combinational ROM
        end
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic int rand_bits(int n);
        int   val;
        logic fb;
        val = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = (val << 1) | int'(fb);
        end
        return val;
    endfunction

    // Column c shows position p at S(c + 7*(p/4) + p%4), zeros elsewhere
    function automatic weight_vec_t expected_vec(int grp_addr, int k, int c);
        weight_vec_t vec;
        rom_word_t   word;
        int          t;
        int          p;
        vec = '0;
        t = k - LOAD_CYCLES - c;                        // Cycles since column skew ended
        if (t >= 0 && t % 7 < 4 && t / 7 < 4) begin
            p = (t / 7) * 4 + t % 7;
            word = rom_word(rom_addr_t'(grp_addr + p / 4), 3 - p % 4);   // data3 is col 0
            for (int ch = 0; ch < 4; ch++) begin
                vec[ch] = word[8*(3-ch) +: 8];          // Channel 0 in top byte
            end
        end
        return vec;
    endfunction

    task automatic check_addr(string name, rom_addr_t got, rom_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %0d exp %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_weights(int col, weight_vec_t got, weight_vec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t b%0d got %h exp %h", $time, col, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %0t %s got %b exp %b", $time, name, got, exp);
        end
    endtask

    // Logical cycle k of a group, stall only gates the read strobe
    task automatic check_cycle(int grp_addr, int k);
        check_bit("weight_rom_read_enable", weight_rom_read_enable,
                  (k < LOAD_CYCLES) && !stall);
        if (k < LOAD_CYCLES) begin
            check_addr("weight_rom_addr", weight_rom_addr, rom_addr_t'(grp_addr + k));
        end
        check_bit("idle", idle, 1'b0);
        check_bit("weight_load_complete", weight_load_complete, 1'b0);
        for (int c = 0; c < 4; c++) begin
            check_weights(c, b_seen[c], expected_vec(grp_addr, k, c));
        end
    endtask

    // Start a layer and follow every group to completion
    task automatic run_layer(int layer, int filter, int stall_bits);
        int grp_addr;
        int k;
        run_stalls = 0;
        @(negedge clk);
        layer_idx  = layer_idx_t'(layer);
        out_ch_idx = out_ch_idx_t'(filter);
        start      = 1'b1;
        stall      = 1'b0;
        for (int g = 0; g < EXP_GROUPS[layer]; g++) begin
            grp_addr = EXP_BASE[layer] + filter * 4 * EXP_GROUPS[layer] + g * 4;
            k = 0;
            while (k < GROUP_CYCLES) begin
                @(negedge clk);
                start = 1'b0;
                stall = (stall_bits > 0) && (rand_bits(stall_bits) == 0);   // 1 in 2**n
                #2;
                check_cycle(grp_addr, k);
                if (stall) begin
                    run_stalls++;
                end else begin
                    k++;
                end
            end
        end
        @(negedge clk);
        stall = 1'b0;
        #2;
        check_bit("weight_load_complete", weight_load_complete, 1'b1);
        check_bit("idle", idle, 1'b0);
        check_bit("weight_rom_read_enable", weight_rom_read_enable, 1'b0);
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        #2;
        check_bit("idle", idle, 1'b1);
        check_bit("weight_load_complete", weight_load_complete, 1'b0);
        check_bit("weight_rom_read_enable", weight_rom_read_enable, 1'b0);
        for (int c = 0; c < 4; c++) begin
            check_weights(c, b_seen[c], '0);
        end
    endtask

    task automatic test_stall();
        run_layer(2, rand_bits(5), 2);                  // Layer 2 has 32 filters
        if (run_stalls == 0) begin
            errors++;
            $display("Stall test drew no stalled cycles");
        end
    endtask

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the loader never finished", cycle_cnt);
            $display("Checks: %0d  errors: %0d", checks, errors);
            $display(">>> FAIL");
            $finish;
        end
    end

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        start      = 1'b0;
        stall      = 1'b0;
        layer_idx  = '0;
        out_ch_idx = '0;
        lfsr_state = 32'h9d94af34;
        errors     = 0;
        checks     = 0;
        cycle_cnt  = 0;
        repeat (3) @(negedge clk);                      // Three reset edges
        reset = 1'b0;
        test_reset_state();
        run_layer(0, rand_bits(3), 0);                  // Single group, 8 filters
        run_layer(1, 5, 0);                             // Two groups from 32 + 5*8
        run_layer(5, 9, 0);                             // Restart straight from done
        test_stall();
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// ==== weight_loader.f ====
+incdir+rtl
rtl/conv_layer_pkg.sv
rtl/loader_pkg.sv
rtl/group_fetch_ctrl.sv
rtl/column_skew_sequencer.sv
rtl/weight_column_buffer.sv
rtl/weight_loader.sv
tb/tb_weight_loader.sv
